// ==== Makefile ====
# Verilator build and run for the SIMD ALU testbench

VERILATOR ?= verilator
TOP       ?= simd_alu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/simd_alu_clkgen.sv ====
// Testbench clock and reset
// 4 ns clock, active-low reset held for the first 10 cycles

`timescale 1ns/1ps

module simd_alu_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== bench/simd_alu_tb.sv ====
// SIMD ALU testbench
// Random requests per operation group, checked against a lane model
// through a queue of expected responses

`timescale 1ns/1ps

module simd_alu_tb;

  localparam int N_WRAP  = 200;
  localparam int N_SAT   = 400;
  localparam int N_EDGE  = 16;
  localparam int N_LOGSH = 200;
  localparam int N_MINMAX = 200;
  localparam int N_TOTAL = N_WRAP + N_SAT + N_EDGE + N_LOGSH + N_MINMAX;
  localparam int CYCLE_LIMIT = 2 * N_TOTAL + 100;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   req_valid_i;
  simd_alu_pkg::alu_req_t req_i;
  logic                   rsp_valid_o;
  simd_alu_pkg::alu_rsp_t rsp_o;

  integer                 seed = 8;
  int                     n_errors = 0;
  int                     n_checks = 0;
  int                     cycle_count = 0;
  logic                   valid_prev = 1'b0;
  logic                   started = 1'b0;
  string                  test_name = "reset_state";
  simd_alu_pkg::alu_rsp_t exp_q [$];
  string                  name_q [$];
  simd_alu_pkg::alu_rsp_t exp_rsp;
  string                  exp_name;

  simd_alu_clkgen clkgen0 (.clk_o(clk_i), .rst_n_o(rst_n_i));

  simd_alu_top dut0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model working one element at a time

  function automatic simd_alu_pkg::alu_rsp_t model_rsp(input simd_alu_pkg::alu_op_e op,
      input simd_alu_pkg::vew_e vew, input logic [63:0] a, input logic [63:0] b);
    simd_alu_pkg::alu_rsp_t rsp;
    int                     w_bits;
    int                     amt;
    logic [66:0]            mask;
    logic [66:0]            ua;
    logic [66:0]            ub;
    logic [66:0]            ur;
    logic signed [66:0]     sa;
    logic signed [66:0]     sb;
    logic signed [66:0]     sr;
    logic signed [66:0]     smax;
    logic signed [66:0]     smin;
    logic                   sat;
    rsp    = '0;
    w_bits = 8 << vew;
    mask   = (67'd1 << w_bits) - 67'd1;
    smax   = (67'sd1 <<< (w_bits - 1)) - 67'sd1;
    smin   = -(67'sd1 <<< (w_bits - 1));
    for (int l = 0; l < 64 / w_bits; l++) begin
      ua  = ({3'b000, a} >> (l * w_bits)) & mask;
      ub  = ({3'b000, b} >> (l * w_bits)) & mask;
      sa  = ua[w_bits-1] ? $signed(ua - (67'd1 << w_bits)) : $signed(ua);
      sb  = ub[w_bits-1] ? $signed(ub - (67'd1 << w_bits)) : $signed(ub);
      amt = int'(ua[5:0]) & (w_bits - 1);
      sat = 1'b0;
      ur  = '0;
      case (op)
        simd_alu_pkg::VAND:  ur = ua & ub;
        simd_alu_pkg::VOR:   ur = ua | ub;
        simd_alu_pkg::VXOR:  ur = ua ^ ub;
        simd_alu_pkg::VADD:  ur = ua + ub;
        simd_alu_pkg::VSUB:  ur = ub - ua;
        simd_alu_pkg::VRSUB: ur = ua - ub;
        simd_alu_pkg::VSADDU: begin
          ur  = ua + ub;
          sat = ur > mask;
          if (sat) ur = mask;
        end
        simd_alu_pkg::VSSUBU: begin
          sat = ub < ua;
          ur  = sat ? 67'd0 : ub - ua;
        end
        simd_alu_pkg::VSADD, simd_alu_pkg::VSSUB: begin
          sr = (op == simd_alu_pkg::VSADD) ? sa + sb : sb - sa;
          // Clamp to the representable range of the element
          if (sr > smax) begin
            sr  = smax;
            sat = 1'b1;
          end else if (sr < smin) begin
            sr  = smin;
            sat = 1'b1;
          end
          ur = sr;
        end
        simd_alu_pkg::VSLL:  ur = ub << amt;
        simd_alu_pkg::VSRL:  ur = ub >> amt;
        simd_alu_pkg::VSRA:  ur = sb >>> amt;
        simd_alu_pkg::VMINU: ur = (ub < ua) ? ub : ua;
        simd_alu_pkg::VMIN:  ur = (sb < sa) ? ub : ua;
        simd_alu_pkg::VMAXU: ur = (ub > ua) ? ub : ua;
        default:             ur = (sb > sa) ? ub : ua;
      endcase
      rsp.result = rsp.result | 64'((ur & mask) << (l * w_bits));
      if (sat) begin
        rsp.vxsat = rsp.vxsat | 8'(((1 << (w_bits / 8)) - 1) << (l * w_bits / 8));
      end
    end
    return rsp;
  endfunction

  // Same value in every lane of the given width
  function automatic logic [63:0] lane_fill(input int vew, input logic [63:0] v);
    logic [63:0] word;
    int          w_bits;
    word   = '0;
    w_bits = 8 << vew;
    for (int l = 0; l < 64 / w_bits; l++) begin
      word = word | ((v & (64'hffff_ffff_ffff_ffff >> (64 - w_bits))) << (l * w_bits));
    end
    return word;
  endfunction

  function automatic logic [63:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic simd_alu_pkg::vew_e rand_vew();
    return simd_alu_pkg::vew_e'({$random(seed)} % 4);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check

  task automatic check_value(input string name, input logic [71:0] exp, input logic [71:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic drive_req(input simd_alu_pkg::alu_op_e op, input simd_alu_pkg::vew_e vew,
      input logic [63:0] a, input logic [63:0] b);
    simd_alu_pkg::alu_req_t req;
    req.op  = op;
    req.vew = vew;
    req.opa = a;
    req.opb = b;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= req;
    started      = 1'b1;
    exp_q.push_back(model_rsp(op, vew, a, b));
    name_q.push_back(test_name);
    // Idle gap now and then
    if ({$random(seed)} % 4 == 0) begin
      @(posedge clk_i);
      req_valid_i <= 1'b0;
    end
  endtask

  // Responses sampled at the falling edge after acceptance
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      check_value("valid_timing", {71'd0, valid_prev}, {71'd0, rsp_valid_o});
      if (!started) begin
        check_value("reset_state", 72'd0, rsp_o);
      end
      if (rsp_valid_o) begin
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("Response arrived with no request outstanding");
        end else begin
          exp_rsp  = exp_q.pop_front();
          exp_name = name_q.pop_front();
          check_value(exp_name, exp_rsp, rsp_o);
        end
      end
      valid_prev = req_valid_i;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("Timeout after %0d cycles with %0d responses missing", cycle_count, exp_q.size());
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [63:0] a;
    logic [63:0] top;
    req_valid_i = 1'b0;
    req_i       = '0;
    @(posedge rst_n_i);
    repeat (3) @(posedge clk_i);

    test_name = "wrap_add_sub";
    for (int i = 0; i < N_WRAP; i++) begin
      drive_req(simd_alu_pkg::alu_op_e'(3 + {$random(seed)} % 3), rand_vew(), rand_word(),
                rand_word());
    end

    test_name = "sat_random";
    for (int i = 0; i < N_SAT; i++) begin
      drive_req(simd_alu_pkg::alu_op_e'(6 + {$random(seed)} % 4), rand_vew(), rand_word(),
                rand_word());
    end

    // max+1, min-1 and 0-1 per width
    test_name = "sat_edge";
    for (int w = 0; w < 4; w++) begin
      top = 64'd1 << ((8 << w) - 1);
      drive_req(simd_alu_pkg::VSADD, simd_alu_pkg::vew_e'(w), lane_fill(w, top - 64'd1),
                lane_fill(w, 64'd1));
      drive_req(simd_alu_pkg::VSSUB, simd_alu_pkg::vew_e'(w), lane_fill(w, 64'd1),
                lane_fill(w, top));
      drive_req(simd_alu_pkg::VSSUBU, simd_alu_pkg::vew_e'(w), lane_fill(w, 64'd1), 64'd0);
      drive_req(simd_alu_pkg::VSADDU, simd_alu_pkg::vew_e'(w), '1, lane_fill(w, 64'd1));
    end

    test_name = "logic_shift";
    for (int i = 0; i < N_LOGSH; i++) begin
      int idx;
      idx = {$random(seed)} % 6;
      drive_req(simd_alu_pkg::alu_op_e'(idx < 3 ? idx : idx + 7), rand_vew(), rand_word(),
                rand_word());
    end

    // Odd requests differ only in the lane sign bits
    test_name = "min_max";
    for (int i = 0; i < N_MINMAX; i++) begin
      simd_alu_pkg::vew_e vew;
      vew = rand_vew();
      a   = rand_word();
      top = 64'd1 << ((8 << vew) - 1);
      drive_req(simd_alu_pkg::alu_op_e'(13 + {$random(seed)} % 4), vew, a,
                (i % 2 == 1) ? a ^ lane_fill(vew, top) : rand_word());
    end

    @(posedge clk_i);
    req_valid_i <= 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== design/simd_addsub_unit.sv ====
// Lane-wise adder/subtractor
// Wrapping and saturating add, subtract and reverse subtract with per-byte
// saturation flags

`timescale 1ns/1ps

`include "simd_alu_cfg.svh"

module simd_addsub_unit (
  input  simd_alu_pkg::elen_t     opa_i,
  input  simd_alu_pkg::elen_t     opb_i,
  input  simd_alu_pkg::vew_e      vew_i,
  input  simd_alu_pkg::alu_ctrl_t ctrl_i,
  output simd_alu_pkg::elen_t     sum_o,
  output simd_alu_pkg::strb_t     sat_o
);

  simd_alu_pkg::elen_t sum_w [4];
  simd_alu_pkg::strb_t sat_w [4];

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned N = (w == 0) ? `SIMD_ALU_LANES8 :
                                (w == 1) ? `SIMD_ALU_LANES16 :
                                (w == 2) ? `SIMD_ALU_LANES32 : 1;
    localparam int unsigned W = `SIMD_ALU_ELEN / N;

    for (genvar l = 0; l < N; l++) begin : g_lane
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W-1:0] x;
      logic [W-1:0] y;
      logic [W-1:0] clamp;
      logic [W:0]   ext;
      logic         ovf_s;
      logic         sat;

      assign a = opa_i[l*W +: W];
      assign b = opb_i[l*W +: W];

      // First operand is b for VSUB-type ops and a otherwise
      assign x = (ctrl_i.subtract && !ctrl_i.reverse) ? b : a;
      assign y = (ctrl_i.subtract && !ctrl_i.reverse) ? a : b;

      // One extra bit holds carry or borrow
      assign ext = ctrl_i.subtract ? ({1'b0, x} - {1'b0, y}) : ({1'b0, x} + {1'b0, y});

      // Signed overflow when the result sign differs from x
      assign ovf_s = (x[W-1] == (y[W-1] ^ ctrl_i.subtract)) && (ext[W-1] != x[W-1]);

      assign sat = ctrl_i.saturate && (ctrl_i.is_signed ? ovf_s : ext[W]);

      always_comb begin
        if (ctrl_i.is_signed) begin
          clamp = x[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
        end else begin
          clamp = ctrl_i.subtract ? {W{1'b0}} : {W{1'b1}};
        end
      end

      assign sum_w[w][l*W +: W]         = sat ? clamp : ext[W-1:0];
      assign sat_w[w][l*(W/8) +: (W/8)] = {(W/8){sat}};
    end
  end

  assign sum_o = sum_w[vew_i];
  assign sat_o = sat_w[vew_i];

endmodule

// ==== design/simd_alu_ctrl.sv ====
// SIMD ALU control
// Decodes the operation for the datapath units, selects the unit result
// and registers the response one cycle after the request

`timescale 1ns/1ps

`include "simd_alu_cfg.svh"

module simd_alu_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  simd_alu_pkg::alu_req_t  req_i,
  output simd_alu_pkg::alu_ctrl_t ctrl_o,
  input  simd_alu_pkg::elen_t     sum_i,
  input  simd_alu_pkg::strb_t     sat_i,
  input  simd_alu_pkg::elen_t     minmax_i,
  input  simd_alu_pkg::elen_t     lsres_i,
  output logic                    rsp_valid_o,
  output simd_alu_pkg::alu_rsp_t  rsp_o
);

  simd_alu_pkg::alu_rsp_t rsp_d;

  ////////////////////////////////////////////////////////////////////////////
  // Decode

  always_comb begin
    ctrl_o.subtract  = req_i.op inside {simd_alu_pkg::VSUB, simd_alu_pkg::VRSUB,
                                        simd_alu_pkg::VSSUBU, simd_alu_pkg::VSSUB};
    ctrl_o.reverse   = req_i.op == simd_alu_pkg::VRSUB;
    ctrl_o.saturate  = req_i.op inside {simd_alu_pkg::VSADDU, simd_alu_pkg::VSADD,
                                        simd_alu_pkg::VSSUBU, simd_alu_pkg::VSSUB};
    ctrl_o.is_signed = req_i.op inside {simd_alu_pkg::VSADD, simd_alu_pkg::VSSUB,
                                        simd_alu_pkg::VMIN, simd_alu_pkg::VMAX};
    ctrl_o.take_max  = req_i.op inside {simd_alu_pkg::VMAXU, simd_alu_pkg::VMAX};

    ctrl_o.unit_sel = simd_alu_pkg::ADDSUB;
    if (req_i.op inside {simd_alu_pkg::VMINU, simd_alu_pkg::VMIN,
                         simd_alu_pkg::VMAXU, simd_alu_pkg::VMAX}) begin
      ctrl_o.unit_sel = simd_alu_pkg::CMP;
    end else if (req_i.op inside {simd_alu_pkg::VAND, simd_alu_pkg::VOR, simd_alu_pkg::VXOR,
                                  simd_alu_pkg::VSLL, simd_alu_pkg::VSRL,
                                  simd_alu_pkg::VSRA}) begin
      ctrl_o.unit_sel = simd_alu_pkg::LOGSH;
    end

    case (req_i.op)
      simd_alu_pkg::VOR:  ctrl_o.lsop = simd_alu_pkg::LS_OR;
      simd_alu_pkg::VXOR: ctrl_o.lsop = simd_alu_pkg::LS_XOR;
      simd_alu_pkg::VSLL: ctrl_o.lsop = simd_alu_pkg::LS_SLL;
      simd_alu_pkg::VSRL: ctrl_o.lsop = simd_alu_pkg::LS_SRL;
      simd_alu_pkg::VSRA: ctrl_o.lsop = simd_alu_pkg::LS_SRA;
      default:            ctrl_o.lsop = simd_alu_pkg::LS_AND;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result select and response register

  always_comb begin
    rsp_d.vxsat = '0;
    case (ctrl_o.unit_sel)
      simd_alu_pkg::CMP:   rsp_d.result = minmax_i;
      simd_alu_pkg::LOGSH: rsp_d.result = lsres_i;
      default: begin
        rsp_d.result = sum_i;
        rsp_d.vxsat  = sat_i;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      rsp_valid_o <= req_valid_i;
      if (req_valid_i) begin
        rsp_o <= rsp_d;
      end
    end
  end

  // Saturation flags only for saturating ops
  a_vxsat_clean: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_valid_i && !ctrl_o.saturate) |=> (rsp_o.vxsat == '0))
    else $error("vxsat set for a non-saturating op");

endmodule

// ==== design/simd_alu_pkg.sv ====
// SIMD ALU package
// Operation and width encodings, request/response and decoded control types

`include "simd_alu_cfg.svh"

package simd_alu_pkg;

  typedef logic [`SIMD_ALU_ELEN-1:0]   elen_t;
  typedef logic [`SIMD_ALU_NBYTES-1:0] strb_t;

  typedef enum logic [1:0] {
    EW8, EW16, EW32, EW64
  } vew_e;

  // Logic, wrapping and saturating arithmetic, shifts, min/max
  typedef enum logic [4:0] {
    VAND, VOR, VXOR,
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VSLL, VSRL, VSRA,
    VMINU, VMIN, VMAXU, VMAX
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    vew_e    vew;
    elen_t   opa;
    elen_t   opb;
  } alu_req_t;

  typedef struct packed {
    elen_t result;
    strb_t vxsat;
  } alu_rsp_t;

  typedef enum logic [1:0] {ADDSUB, CMP, LOGSH} unit_sel_e;

  typedef enum logic [2:0] {LS_AND, LS_OR, LS_XOR, LS_SLL, LS_SRL, LS_SRA} lsop_e;

  typedef struct packed {
    unit_sel_e unit_sel;
    logic      subtract;
    logic      reverse;
    logic      saturate;
    logic      is_signed;
    logic      take_max;
    lsop_e     lsop;
  } alu_ctrl_t;

endpackage

// ==== design/simd_alu_top.sv ====
// SIMD ALU top level
// Control with response register and the three combinational datapath units

`timescale 1ns/1ps

`include "simd_alu_cfg.svh"

module simd_alu_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  input  simd_alu_pkg::alu_req_t req_i,
  output logic                   rsp_valid_o,
  output simd_alu_pkg::alu_rsp_t rsp_o
);

  simd_alu_pkg::alu_ctrl_t ctrl;
  simd_alu_pkg::elen_t     sum;
  simd_alu_pkg::strb_t     sat;
  simd_alu_pkg::elen_t     minmax;
  simd_alu_pkg::elen_t     lsres;

  simd_alu_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .ctrl_o      (ctrl),
    .sum_i       (sum),
    .sat_i       (sat),
    .minmax_i    (minmax),
    .lsres_i     (lsres),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  simd_addsub_unit u_addsub (
    .opa_i  (req_i.opa),
    .opb_i  (req_i.opb),
    .vew_i  (req_i.vew),
    .ctrl_i (ctrl),
    .sum_o  (sum),
    .sat_o  (sat)
  );

  simd_cmp_unit u_cmp (
    .opa_i    (req_i.opa),
    .opb_i    (req_i.opb),
    .vew_i    (req_i.vew),
    .ctrl_i   (ctrl),
    .minmax_o (minmax)
  );

  simd_logic_shift_unit u_logsh (
    .opa_i   (req_i.opa),
    .opb_i   (req_i.opb),
    .vew_i   (req_i.vew),
    .ctrl_i  (ctrl),
    .lsres_o (lsres)
  );

endmodule

// ==== design/simd_cmp_unit.sv ====
// Lane-wise compare unit
// Signed or unsigned b < a per element, returning the minimum or maximum

`timescale 1ns/1ps

`include "simd_alu_cfg.svh"

module simd_cmp_unit (
  input  simd_alu_pkg::elen_t     opa_i,
  input  simd_alu_pkg::elen_t     opb_i,
  input  simd_alu_pkg::vew_e      vew_i,
  input  simd_alu_pkg::alu_ctrl_t ctrl_i,
  output simd_alu_pkg::elen_t     minmax_o
);

  simd_alu_pkg::elen_t minmax_w [4];

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned N = (w == 0) ? `SIMD_ALU_LANES8 :
                                (w == 1) ? `SIMD_ALU_LANES16 :
                                (w == 2) ? `SIMD_ALU_LANES32 : 1;
    localparam int unsigned W = `SIMD_ALU_ELEN / N;

    for (genvar l = 0; l < N; l++) begin : g_lane
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic         less;

      assign a = opa_i[l*W +: W];
      assign b = opb_i[l*W +: W];

      // Sign extension only for signed compares
      assign less = $signed({ctrl_i.is_signed & b[W-1], b}) <
                    $signed({ctrl_i.is_signed & a[W-1], a});

      assign minmax_w[w][l*W +: W] = (less ^ ctrl_i.take_max) ? b : a;
    end
  end

  assign minmax_o = minmax_w[vew_i];

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  // Width must be known whenever control routes this unit to the output
  always_comb begin
    if (ctrl_i.unit_sel == simd_alu_pkg::CMP) begin
      a_vew_known: assert (!$isunknown(vew_i))
        else $error("element width unknown on a min/max op");
    end
  end

endmodule

// ==== design/simd_logic_shift_unit.sv ====
// Logic and shift unit
// Bitwise AND/OR/XOR over the word and lane-wise SLL/SRL/SRA of b by a

`timescale 1ns/1ps

`include "simd_alu_cfg.svh"

module simd_logic_shift_unit (
  input  simd_alu_pkg::elen_t     opa_i,
  input  simd_alu_pkg::elen_t     opb_i,
  input  simd_alu_pkg::vew_e      vew_i,
  input  simd_alu_pkg::alu_ctrl_t ctrl_i,
  output simd_alu_pkg::elen_t     lsres_o
);

  simd_alu_pkg::elen_t shres_w [4];

  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned N  = (w == 0) ? `SIMD_ALU_LANES8 :
                                 (w == 1) ? `SIMD_ALU_LANES16 :
                                 (w == 2) ? `SIMD_ALU_LANES32 : 1;
    localparam int unsigned W  = `SIMD_ALU_ELEN / N;
    localparam int unsigned SW = $clog2(W);

    for (genvar l = 0; l < N; l++) begin : g_lane
      logic [W-1:0]  b;
      logic [SW-1:0] amt;

      // Shift amount from the low bits of the a element
      assign amt = opa_i[l*W +: SW];
      assign b   = opb_i[l*W +: W];

      always_comb begin
        case (ctrl_i.lsop)
          simd_alu_pkg::LS_SLL: shres_w[w][l*W +: W] = b << amt;
          simd_alu_pkg::LS_SRA: shres_w[w][l*W +: W] = $signed(b) >>> amt;
          default:              shres_w[w][l*W +: W] = b >> amt;
        endcase
      end
    end
  end

  always_comb begin
    case (ctrl_i.lsop)
      simd_alu_pkg::LS_AND: lsres_o = opa_i & opb_i;
      simd_alu_pkg::LS_OR:  lsres_o = opa_i | opb_i;
      simd_alu_pkg::LS_XOR: lsres_o = opa_i ^ opb_i;
      default:              lsres_o = shres_w[vew_i];
    endcase
  end

endmodule

// ==== include/simd_alu_cfg.svh ====
// SIMD ALU configuration
// Datapath width and lane counts shared by the package and datapath units

`ifndef SIMD_ALU_CFG_SVH
`define SIMD_ALU_CFG_SVH

// Datapath width in bits
`define SIMD_ALU_ELEN 64

// Bytes per datapath word
`define SIMD_ALU_NBYTES 8

// Lanes per element width
`define SIMD_ALU_LANES8  8
`define SIMD_ALU_LANES16 4
`define SIMD_ALU_LANES32 2

`endif

// ==== sources.f ====
+incdir+include
design/simd_alu_pkg.sv
design/simd_alu_ctrl.sv
design/simd_addsub_unit.sv
design/simd_cmp_unit.sv
design/simd_logic_shift_unit.sv
design/simd_alu_top.sv
bench/simd_alu_clkgen.sv
bench/simd_alu_tb.sv
